/* mac_arbiter.sv */
`timescale 1ns/1ps

module mac_arbiter (
	input logic             clk,
	input logic             reset,
	mac_bus_if.arbiter_side poly_bus,
	mac_bus_if.arbiter_side sop_bus,
	mac_bus_if.engine       dp_bus
);

	// Owner encoding is private to the arbiter
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_POLY,
		OWN_SOP
	} owner_t;

	// Current bus owner, its gnt is high while this register names it
	owner_t owner_q;
	// Owner for the next cycle
	owner_t owner_d;
	// Most recent engine selected, used to break a tie
	owner_t last_q;
	logic   bus_free;

	always_comb begin
		// The bus is free when nobody owns it or the owner has just dropped req
		bus_free = (owner_q == OWN_NONE) ||
			(owner_q == OWN_POLY && !poly_bus.req) ||
			(owner_q == OWN_SOP && !sop_bus.req);
		owner_d = owner_q;
		if (bus_free) begin
			if (poly_bus.req && sop_bus.req) begin
				// Both waiting so the engine that did not own the bus last wins
				owner_d = (last_q == OWN_POLY) ? OWN_SOP : OWN_POLY;
			end else if (poly_bus.req) begin
				owner_d = OWN_POLY;
			end else if (sop_bus.req) begin
				owner_d = OWN_SOP;
			end else begin
				owner_d = OWN_NONE;
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			owner_q <= OWN_NONE;
			last_q <= OWN_NONE;
		end else begin
			owner_q <= owner_d;
			if (owner_d != OWN_NONE) begin
				last_q <= owner_d;
			end
		end
	end

	// Grants come straight from the owner register, one cycle after selection
	assign poly_bus.gnt = (owner_q == OWN_POLY);
	assign sop_bus.gnt = (owner_q == OWN_SOP);

	// Forward the owner's operands, the datapath sees req only in granted cycles
	always_comb begin
		dp_bus.req = 1'b0;
		dp_bus.in_1 = '0;
		dp_bus.in_2 = '0;
		dp_bus.in_add = '0;
		dp_bus.mul_sel = 1'b0;
		dp_bus.add_sel = 1'b0;
		case (owner_q)
			OWN_POLY: begin
				dp_bus.req = 1'b1;
				dp_bus.in_1 = poly_bus.in_1;
				dp_bus.in_2 = poly_bus.in_2;
				dp_bus.in_add = poly_bus.in_add;
				dp_bus.mul_sel = poly_bus.mul_sel;
				dp_bus.add_sel = poly_bus.add_sel;
			end
			OWN_SOP: begin
				dp_bus.req = 1'b1;
				dp_bus.in_1 = sop_bus.in_1;
				dp_bus.in_2 = sop_bus.in_2;
				dp_bus.in_add = sop_bus.in_add;
				dp_bus.mul_sel = sop_bus.mul_sel;
				dp_bus.add_sel = sop_bus.add_sel;
			end
			default: begin
			end
		endcase
	end

	// One shared result goes back to both engines
	assign poly_bus.result = dp_bus.result;
	assign sop_bus.result = dp_bus.result;

	a_one_grant: assert property (
		@(posedge clk) disable iff (reset)
		!(poly_bus.gnt && sop_bus.gnt)
	) else $error("mac_arbiter: both engines granted");

	// A grant only ever answers a request seen in the cycle before
	a_poly_gnt_req: assert property (
		@(posedge clk) disable iff (reset)
		$rose(poly_bus.gnt) |-> $past(poly_bus.req)
	) else $error("mac_arbiter: poly gnt without req");

	a_sop_gnt_req: assert property (
		@(posedge clk) disable iff (reset)
		$rose(sop_bus.gnt) |-> $past(sop_bus.req)
	) else $error("mac_arbiter: sop gnt without req");

endmodule

/* mac_bus_if.sv */
`timescale 1ns/1ps

interface mac_bus_if;
	import mac_pkg::*;

	// Request from an engine, or the forwarded valid-operation bit on the datapath side
	logic req;
	// Grant from the arbiter, registered one cycle after selection
	logic gnt;

	// Multiplicand, multiplier and addend operands
	data_t in_1;
	data_t in_2;
	data_t in_add;

	// Feedback selects, high takes the current result in place of in_1 or in_add
	logic mul_sel;
	logic add_sel;

	// Registered datapath result, shared back to both engines
	result_t result;

	// Engine side of the bus
	modport engine (
		output req,
		output in_1,
		output in_2,
		output in_add,
		output mul_sel,
		output add_sel,
		input  gnt,
		input  result
	);

	// Arbiter side facing one engine
	modport arbiter_side (
		input  req,
		input  in_1,
		input  in_2,
		input  in_add,
		input  mul_sel,
		input  add_sel,
		output gnt,
		output result
	);

	// The datapath only sees the forwarded operation
	modport datapath (
		input  req,
		input  in_1,
		input  in_2,
		input  in_add,
		input  mul_sel,
		input  add_sel,
		output result
	);

endinterface

/* mac_cluster.f */
+incdir+.
mac_pkg.sv
mac_bus_if.sv
mac_datapath.sv
mac_arbiter.sv
trinomial_engine.sv
sop_engine.sv
mac_cluster_top.sv
tb_mac_cluster.sv

/* mac_cluster_top.sv */
`timescale 1ns/1ps

module mac_cluster_top #(
	parameter int SOP_DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             poly_start,
	input  mac_pkg::data_t   poly_a,
	input  mac_pkg::data_t   poly_b,
	input  mac_pkg::data_t   poly_c,
	input  mac_pkg::data_t   poly_x,
	output logic             poly_busy,
	output logic             poly_valid,
	output mac_pkg::result_t poly_result,
	input  logic             sop_valid_in,
	input  logic             sop_last,
	input  mac_pkg::data_t   sop_a,
	input  mac_pkg::data_t   sop_x,
	output logic             sop_busy,
	output logic             sop_valid,
	output mac_pkg::result_t sop_result
);

	// One bus per engine and one from the arbiter to the datapath
	mac_bus_if poly_bus ();
	mac_bus_if sop_bus ();
	mac_bus_if dp_bus ();

	trinomial_engine u_poly (
		.clk        (clk),
		.reset      (reset),
		.start      (poly_start),
		.a          (poly_a),
		.b          (poly_b),
		.c          (poly_c),
		.x          (poly_x),
		.busy       (poly_busy),
		.valid      (poly_valid),
		.result_out (poly_result),
		.bus        (poly_bus.engine)
	);

	sop_engine #(
		.SOP_DEPTH (SOP_DEPTH)
	) u_sop (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (sop_valid_in),
		.last       (sop_last),
		.a          (sop_a),
		.x          (sop_x),
		.busy       (sop_busy),
		.valid      (sop_valid),
		.result_out (sop_result),
		.bus        (sop_bus.engine)
	);

	// Arbiter acts as the engine towards the datapath
	mac_arbiter u_arb (
		.clk      (clk),
		.reset    (reset),
		.poly_bus (poly_bus.arbiter_side),
		.sop_bus  (sop_bus.arbiter_side),
		.dp_bus   (dp_bus.engine)
	);

	mac_datapath u_dp (
		.clk   (clk),
		.reset (reset),
		.bus   (dp_bus.datapath)
	);

endmodule

/* mac_datapath.sv */
`timescale 1ns/1ps

module mac_datapath (
	input logic         clk,
	input logic         reset,
	mac_bus_if.datapath bus
);
	import mac_pkg::*;

	// The one result register shared by both engines
	result_t acc_q;

	// Operands after the feedback selects
	result_t mcand;
	result_t addend;
	result_t next_acc;

	// Multiplicand is either the fresh operand or the previous result
	// The trinomial second pass uses the feedback path here
	assign mcand = bus.mul_sel ? acc_q : result_t'(bus.in_1);

	// Addend is either the fresh operand or the running result
	// The sum of products accumulates through this path
	assign addend = bus.add_sel ? acc_q : result_t'(bus.in_add);

	// Everything is computed at RES_W bits so the sum wraps modulo 2**RES_W
	// Low product bits only depend on low operand bits so the truncation is exact
	assign next_acc = mcand * result_t'(bus.in_2) + addend;

	// Register updates only in cycles with an owner
	// Idle cycles hold the last result for the engine that is about to capture it
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			acc_q <= '0;
		end else begin
			if (bus.req) begin
				acc_q <= next_acc;
			end
		end
	end

	// Result is visible one cycle after the operands
	assign bus.result = acc_q;

	// The engines never ask for both feedback paths in one operation
	// A forwarded operation with both selects high would square the result into itself
	a_single_feedback: assert property (
		@(posedge clk) disable iff (reset)
		bus.req |-> !(bus.mul_sel && bus.add_sel)
	) else $error("mac_datapath: mul_sel and add_sel high together");

endmodule

/* mac_pkg.sv */
package mac_pkg;

	// Operand width shared by both engines and the datapath inputs
	localparam int DATA_W = 8;

	// Result width, every result wraps modulo 2**RES_W
	localparam int RES_W = 17;

	// One unsigned operand
	typedef logic [DATA_W-1:0] data_t;

	// One datapath result, also the width of both result outputs
	typedef logic [RES_W-1:0] result_t;

	// Trinomial engine states
	// PASS1 and PASS2 are the cycles in which that pass's result is on the bus
	typedef enum logic [2:0] {
		POLY_IDLE,
		POLY_REQ,
		POLY_PASS1,
		POLY_PASS2,
		POLY_DONE
	} poly_state_t;

	// Sum-of-products engine states
	// FILL doubles as the idle state while the pair buffer is empty
	typedef enum logic [1:0] {
		SOP_FILL,
		SOP_REQ,
		SOP_RUN,
		SOP_DONE
	} sop_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the mac_cluster testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
	-f mac_cluster.f \
	--top-module tb_mac_cluster \
	--Mdir obj_dir \
	-o sim_mac_cluster
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mac_cluster > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The log decides pass or fail
if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi

echo "Simulation PASSED"
exit 0

/* sop_engine.sv */
`timescale 1ns/1ps

module sop_engine #(
	parameter int SOP_DEPTH = 8
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  logic             last,
	input  mac_pkg::data_t   a,
	input  mac_pkg::data_t   x,
	output logic             busy,
	output logic             valid,
	output mac_pkg::result_t result_out,
	mac_bus_if.engine        bus
);
	import mac_pkg::*;

	// Count runs 0..SOP_DEPTH, the buffer index only 0..SOP_DEPTH-1
	localparam int CNT_W = $clog2(SOP_DEPTH + 1);
	localparam int IDX_W = (SOP_DEPTH > 1) ? $clog2(SOP_DEPTH) : 1;
	localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(SOP_DEPTH);
	localparam logic [CNT_W-1:0] ONE_C = CNT_W'(1);

	sop_state_t state_q;
	logic [CNT_W-1:0] count_q;
	// Pair index driven in the current RUN cycle
	logic [CNT_W-1:0] idx_q;
	logic [CNT_W-1:0] cur_idx;
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	data_t a_mem [SOP_DEPTH];
	data_t x_mem [SOP_DEPTH];
	result_t sum_q;

	logic accept;
	logic write_en;
	logic pending;
	logic drive;
	logic final_pair;

	// DONE accepts pairs too since busy is already low there
	assign accept = valid_in && (state_q == SOP_FILL || state_q == SOP_DONE);
	// Pairs past the buffer depth are dropped but last still closes the batch
	assign write_en = accept && (count_q < DEPTH_C);
	assign wr_idx = count_q[IDX_W-1:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= SOP_FILL;
			count_q <= '0;
			idx_q <= '0;
		end else begin
			case (state_q)
				SOP_FILL, SOP_DONE: begin
					state_q <= (accept && last) ? SOP_REQ : SOP_FILL;
					if (write_en) begin
						count_q <= count_q + ONE_C;
					end
				end
				SOP_REQ: begin
					// Pair 0 goes out in the granted cycle
					if (bus.gnt) begin
						state_q <= SOP_RUN;
						idx_q <= ONE_C;
					end
				end
				SOP_RUN: begin
					// Index equal to count marks the capture cycle
					if (idx_q == count_q) begin
						state_q <= SOP_DONE;
						count_q <= '0;
					end else begin
						idx_q <= idx_q + ONE_C;
					end
				end
				default: begin
					state_q <= SOP_FILL;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			a_mem[wr_idx] <= a;
			x_mem[wr_idx] <= x;
		end
		if (state_q == SOP_RUN && idx_q == count_q) begin
			sum_q <= bus.result;
		end
	end

	// Operations still to be sent on the bus
	assign pending = (state_q == SOP_REQ) || (state_q == SOP_RUN && idx_q != count_q);
	assign drive = bus.gnt && pending;
	assign cur_idx = (state_q == SOP_RUN) ? idx_q : '0;
	assign rd_idx = cur_idx[IDX_W-1:0];
	assign final_pair = (cur_idx + ONE_C == count_q);

	// Request drops with the last pair so no empty cycle follows it on the datapath
	assign bus.req = pending && !(drive && final_pair);

	assign bus.in_1 = drive ? a_mem[rd_idx] : '0;
	assign bus.in_2 = drive ? x_mem[rd_idx] : '0;
	assign bus.in_add = '0;
	assign bus.mul_sel = 1'b0;
	// First pair starts from zero, the rest add onto the running result
	assign bus.add_sel = drive && (cur_idx != '0);

	assign busy = (state_q == SOP_REQ) || (state_q == SOP_RUN) ||
		(state_q == SOP_FILL && count_q != '0);
	assign valid = (state_q == SOP_DONE);
	assign result_out = valid ? sum_q : '0;

	a_fill_bound: assert property (
		@(posedge clk) disable iff (reset)
		count_q <= DEPTH_C
	) else $error("sop_engine: fill count above SOP_DEPTH");

endmodule

/* tb_mac_tasks.svh */
// Wrong 17-bit results are reported with both values
task automatic compare_result(input string name, input result_t got, input result_t exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
	end
endtask

task automatic expect_level(input string name, input logic got, input logic exp);
	checks++;
	if (got !== exp) begin
		errors++;
		$display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

// (a*x + b)*x + c in plain integer arithmetic, wrapped at the end
function automatic result_t trinomial_ref(input data_t a, b, c, x);
	int first;
	int full;
	first = int'(a) * int'(x) + int'(b);
	full = first * int'(x) + int'(c);
	return result_t'(full % RES_MOD);
endfunction

// Random batch of n pairs, the sum only counts pairs that fit the buffer
task automatic make_pairs(input int n, output result_t sum);
	int acc;
	acc = 0;
	for (int i = 0; i < n; i++) begin
		pair_a[i] = data_t'($random(seed));
		pair_x[i] = data_t'($random(seed));
		if (i < SOP_DEPTH) begin
			acc = (acc + int'(pair_a[i]) * int'(pair_x[i])) % RES_MOD;
		end
	end
	sum = result_t'(acc);
endtask

// One start pulse, busy has to be up one cycle later
task automatic pulse_poly_start(input data_t a, b, c, x);
	@(negedge clk);
	poly_start = 1'b1;
	poly_a = a;
	poly_b = b;
	poly_c = c;
	poly_x = x;
	@(negedge clk);
	poly_start = 1'b0;
	expect_level("poly_busy", poly_busy, 1'b1);
endtask

// Streams pair_a and pair_x with last on the final pair
task automatic send_pairs(input int n);
	for (int i = 0; i < n; i++) begin
		@(negedge clk);
		sop_valid_in = 1'b1;
		sop_a = pair_a[i];
		sop_x = pair_x[i];
		sop_last = (i == n - 1);
	end
	@(negedge clk);
	sop_valid_in = 1'b0;
	sop_last = 1'b0;
	expect_level("sop_busy", sop_busy, 1'b1);
endtask

// Result must read zero in every cycle except the pulse itself
task automatic await_poly(input result_t exp);
	int   waited;
	logic seen;
	waited = 0;
	seen = 1'b0;
	while (!seen && waited < WAIT_LIMIT) begin
		@(negedge clk);
		waited++;
		if (poly_valid) begin
			seen = 1'b1;
			compare_result("poly_result", poly_result, exp);
			expect_level("poly_busy", poly_busy, 1'b0);
		end else begin
			compare_result("poly_result", poly_result, '0);
		end
	end
	checks++;
	if (!seen) begin
		errors++;
		$display("No poly_valid pulse within %0d cycles", WAIT_LIMIT);
	end
	@(negedge clk);
	expect_level("poly_valid", poly_valid, 1'b0);
	compare_result("poly_result", poly_result, '0);
endtask

// Same wait for the sum, poly_quiet also demands an idle trinomial engine
task automatic await_sop(input result_t exp, input logic poly_quiet);
	int   waited;
	logic seen;
	waited = 0;
	seen = 1'b0;
	while (!seen && waited < WAIT_LIMIT) begin
		@(negedge clk);
		waited++;
		if (poly_quiet) begin
			expect_level("poly_valid", poly_valid, 1'b0);
		end
		if (sop_valid) begin
			seen = 1'b1;
			compare_result("sop_result", sop_result, exp);
			expect_level("sop_busy", sop_busy, 1'b0);
		end else begin
			compare_result("sop_result", sop_result, '0);
		end
	end
	checks++;
	if (!seen) begin
		errors++;
		$display("No sop_valid pulse within %0d cycles", WAIT_LIMIT);
	end
	@(negedge clk);
	expect_level("sop_valid", sop_valid, 1'b0);
	compare_result("sop_result", sop_result, '0);
endtask

task automatic run_trinomial(input data_t a, b, c, x);
	pulse_poly_start(a, b, c, x);
	await_poly(trinomial_ref(a, b, c, x));
endtask

task automatic reset_values_check();
	expect_level("poly_busy", poly_busy, 1'b0);
	expect_level("sop_busy", sop_busy, 1'b0);
	expect_level("poly_valid", poly_valid, 1'b0);
	expect_level("sop_valid", sop_valid, 1'b0);
	compare_result("poly_result", poly_result, '0);
	compare_result("sop_result", sop_result, '0);
endtask

task automatic trinomial_alone();
	// Zeros, all ones (wraps past 2**17), small values, zero multiplier in pass 1
	run_trinomial(8'd0, 8'd0, 8'd0, 8'd0);
	run_trinomial(8'd255, 8'd255, 8'd255, 8'd255);
	run_trinomial(8'd1, 8'd2, 8'd3, 8'd4);
	run_trinomial(8'd0, 8'd17, 8'd99, 8'd200);
	for (int i = 0; i < POLY_RUNS - 4; i++) begin
		run_trinomial(data_t'($random(seed)), data_t'($random(seed)),
			data_t'($random(seed)), data_t'($random(seed)));
	end
endtask

// Batches of 1, 3 and a full buffer, with no trinomial started
task automatic sum_of_products_alone();
	result_t sum;
	int      n;
	for (int k = 0; k < 3; k++) begin
		n = (k == 0) ? 1 : ((k == 1) ? 3 : SOP_DEPTH);
		make_pairs(n, sum);
		send_pairs(n);
		await_sop(sum, 1'b1);
	end
endtask

// Start pulse and first pair share one edge
// Single-pair rounds make both requests rise together and test the tie break
task automatic both_engines_contend();
	data_t   a;
	data_t   b;
	data_t   c;
	data_t   x;
	result_t sum;
	int      n;
	for (int r = 0; r < CONTENTION_ROUNDS; r++) begin
		a = data_t'($random(seed));
		b = data_t'($random(seed));
		c = data_t'($random(seed));
		x = data_t'($random(seed));
		n = (r < 4) ? 1 : 1 + ($random(seed) & 3);
		make_pairs(n, sum);
		fork
			begin
				pulse_poly_start(a, b, c, x);
				await_poly(trinomial_ref(a, b, c, x));
			end
			begin
				send_pairs(n);
				await_sop(sum, 1'b0);
			end
		join
	end
endtask

task automatic busy_rule_checks();
	data_t   a1;
	data_t   b1;
	data_t   c1;
	data_t   x1;
	result_t sum;
	a1 = data_t'($random(seed));
	b1 = data_t'($random(seed));
	c1 = data_t'($random(seed));
	x1 = data_t'($random(seed));
	pulse_poly_start(a1, b1, c1, x1);
	// Busy was seen high above, so this second start falls into the running sequence
	pulse_poly_start(data_t'($random(seed)), data_t'($random(seed)),
		data_t'($random(seed)), data_t'($random(seed)));
	await_poly(trinomial_ref(a1, b1, c1, x1));
	// A second pulse here would mean the ignored start was taken
	repeat (8) begin
		@(negedge clk);
		expect_level("poly_valid", poly_valid, 1'b0);
	end
	// Three pairs past the buffer depth drop out of the sum
	make_pairs(SOP_DEPTH + 3, sum);
	send_pairs(SOP_DEPTH + 3);
	await_sop(sum, 1'b1);
endtask

/* tb_mac_cluster.sv */
`timescale 1ns/1ps

module tb_mac_cluster;
	import mac_pkg::*;

	// Pair buffer depth handed to the DUT
	localparam int SOP_DEPTH = 8;
	// Every result wraps modulo 2**RES_W
	localparam int RES_MOD = 1 << RES_W;
	// Room for the overflow batch, which is longer than the buffer
	localparam int MAX_PAIRS = 16;
	// Longest wait for one valid pulse, generous even under contention
	localparam int WAIT_LIMIT = 60;

	// Four directed trinomials and twenty random ones
	localparam int POLY_RUNS = 24;
	localparam int CONTENTION_ROUNDS = 12;
	localparam int CONT_MAX_PAIRS = 4;

	// Worst case of each test summed, then a margin on top
	// A lone trinomial needs about 7 cycles and a batch of n pairs about 2n+6
	localparam int TIMEOUT_CYCLES = 10 + POLY_RUNS * 12 +
		3 * (2 * SOP_DEPTH + 8) +
		CONTENTION_ROUNDS * (2 * CONT_MAX_PAIRS + 16) +
		(12 + 8 + 2 * (SOP_DEPTH + 3) + 8) + 200;

	logic    clk;
	logic    reset;
	logic    poly_start;
	data_t   poly_a;
	data_t   poly_b;
	data_t   poly_c;
	data_t   poly_x;
	logic    poly_busy;
	logic    poly_valid;
	result_t poly_result;
	logic    sop_valid_in;
	logic    sop_last;
	data_t   sop_a;
	data_t   sop_x;
	logic    sop_busy;
	logic    sop_valid;
	result_t sop_result;

	int seed;
	int errors;
	int checks;
	int cycles = 0;

	// Operand pairs of the batch being sent to the sum-of-products engine
	data_t pair_a [MAX_PAIRS];
	data_t pair_x [MAX_PAIRS];

	mac_cluster_top #(
		.SOP_DEPTH (SOP_DEPTH)
	) dut0 (
		.clk          (clk),
		.reset        (reset),
		.poly_start   (poly_start),
		.poly_a       (poly_a),
		.poly_b       (poly_b),
		.poly_c       (poly_c),
		.poly_x       (poly_x),
		.poly_busy    (poly_busy),
		.poly_valid   (poly_valid),
		.poly_result  (poly_result),
		.sop_valid_in (sop_valid_in),
		.sop_last     (sop_last),
		.sop_a        (sop_a),
		.sop_x        (sop_x),
		.sop_busy     (sop_busy),
		.sop_valid    (sop_valid),
		.sop_result   (sop_result)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Ends a run that hangs somewhere
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	`include "tb_mac_tasks.svh"

	initial begin
		seed = 67;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		poly_start = 1'b0;
		poly_a = '0;
		poly_b = '0;
		poly_c = '0;
		poly_x = '0;
		sop_valid_in = 1'b0;
		sop_last = 1'b0;
		sop_a = '0;
		sop_x = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		reset_values_check();
		trinomial_alone();
		sum_of_products_alone();
		both_engines_contend();
		busy_rule_checks();

		repeat (5) @(negedge clk);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* trinomial_engine.sv */
`timescale 1ns/1ps

module trinomial_engine (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  mac_pkg::data_t   a,
	input  mac_pkg::data_t   b,
	input  mac_pkg::data_t   c,
	input  mac_pkg::data_t   x,
	output logic             busy,
	output logic             valid,
	output mac_pkg::result_t result_out,
	mac_bus_if.engine        bus
);
	import mac_pkg::*;

	poly_state_t state_q;

	// Latched operands of the running trinomial
	data_t a_q;
	data_t b_q;
	data_t c_q;
	data_t x_q;

	// Final result held for the valid cycle
	result_t res_q;

	logic accept;
	logic drive_pass1;
	logic drive_pass2;

	// Start is taken whenever the engine is not busy, DONE included
	assign accept = start && (state_q == POLY_IDLE || state_q == POLY_DONE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= POLY_IDLE;
		end else begin
			case (state_q)
				POLY_IDLE, POLY_DONE: begin
					state_q <= accept ? POLY_REQ : POLY_IDLE;
				end
				POLY_REQ: begin
					// Pass 1 goes out in the first granted cycle
					if (bus.gnt) begin
						state_q <= POLY_PASS1;
					end
				end
				POLY_PASS1: begin
					state_q <= POLY_PASS2;
				end
				POLY_PASS2: begin
					state_q <= POLY_DONE;
				end
				default: begin
					state_q <= POLY_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			a_q <= a;
			b_q <= b;
			c_q <= c;
			x_q <= x;
		end
		// Pass 2 result sits on the bus for exactly this cycle
		if (state_q == POLY_PASS2) begin
			res_q <= bus.result;
		end
	end

	// Request drops as pass 2 goes out, so the grant ends right after it
	assign bus.req = (state_q == POLY_REQ);

	assign drive_pass1 = bus.gnt && (state_q == POLY_REQ);
	// Pass 1 result is visible now and feeds back as the multiplicand
	assign drive_pass2 = bus.gnt && (state_q == POLY_PASS1);

	always_comb begin
		bus.in_1 = '0;
		bus.in_2 = '0;
		bus.in_add = '0;
		bus.mul_sel = 1'b0;
		bus.add_sel = 1'b0;
		if (drive_pass1) begin
			// r = a*x + b
			bus.in_1 = a_q;
			bus.in_2 = x_q;
			bus.in_add = b_q;
		end else if (drive_pass2) begin
			// r*x + c with r taken from the result register
			bus.in_2 = x_q;
			bus.in_add = c_q;
			bus.mul_sel = 1'b1;
		end
	end

	assign busy = (state_q == POLY_REQ) || (state_q == POLY_PASS1) || (state_q == POLY_PASS2);
	assign valid = (state_q == POLY_DONE);
	// Output reads zero outside the valid pulse
	assign result_out = valid ? res_q : '0;

	// The arbiter keeps gnt for one cycle after req drops so pass 2 reaches the datapath
	a_pass2_granted: assert property (
		@(posedge clk) disable iff (reset)
		(state_q == POLY_PASS1) |-> bus.gnt
	) else $error("trinomial_engine: no grant for pass 2");

endmodule
